/* project.f */
+incdir+rtl
rtl/imuldiv_pkg.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_mul_ctrl.sv
rtl/imuldiv_div_iterative.sv
rtl/imuldiv_unit.sv
verif/tb_clock.sv
verif/imuldiv_assertions.sv
verif/imuldiv_tb.sv

/* rtl/imuldiv_config.svh */
/*
 * multiply/divide unit sizing: operand width and iteration count
 */

`ifndef IMULDIV_CONFIG_SVH
`define IMULDIV_CONFIG_SVH

// operand width, responses are twice this wide
`define IMULDIV_XLEN 32

// one calc cycle per operand bit
`define IMULDIV_ITERS 32

// iteration counter width, must hold IMULDIV_ITERS - 1
`define IMULDIV_CNT_W 6

`endif

/* rtl/imuldiv_div_iterative.sv */
/*
 * restoring divider, signed or unsigned, one quotient bit per cycle;
 * remainder in the upper half of the response, quotient in the lower
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     req_a,
  input  logic [`IMULDIV_XLEN-1:0]     req_b,
  input  logic                         req_signed,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  localparam logic [`IMULDIV_CNT_W-1:0] last_cnt = `IMULDIV_CNT_W'(`IMULDIV_ITERS - 1);

  imuldiv_pkg::iter_state_e state;
  logic [`IMULDIV_CNT_W-1:0] cnt;
  logic                      req_go;
  logic                      resp_go;

  // payload registers
  logic [`IMULDIV_XLEN-1:0] rem_reg;
  logic [`IMULDIV_XLEN-1:0] quo_reg;   // dividend bits out, quotient bits in
  logic [`IMULDIV_XLEN-1:0] dvs_reg;
  logic                     q_sign;
  logic                     r_sign;
  logic                     div_zero;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= imuldiv_pkg::st_calc;
            cnt   <= '0;
          end
        end
        imuldiv_pkg::st_calc: begin
          if (cnt == last_cnt) begin
            state <= imuldiv_pkg::st_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        imuldiv_pkg::st_done: begin
          if (resp_go) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  assign req_rdy  = (state == imuldiv_pkg::st_idle);
  assign resp_val = (state == imuldiv_pkg::st_done);

  // --------------------
  // datapath
  // --------------------
  // operand signs only count for a signed divide
  logic a_neg;
  logic b_neg;
  logic [`IMULDIV_XLEN:0]   shifted;   // one spare bit for the borrow
  logic [`IMULDIV_XLEN:0]   diff;
  logic                     q_bit;

  assign a_neg = req_signed && req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed && req_b[`IMULDIV_XLEN-1];

  // bring down the next dividend bit and try the subtract
  assign shifted = {rem_reg, quo_reg[`IMULDIV_XLEN-1]};
  assign diff    = shifted - {1'b0, dvs_reg};
  assign q_bit   = !diff[`IMULDIV_XLEN];

  always_ff @(posedge clk) begin
    if (req_go) begin
      rem_reg  <= '0;
      quo_reg  <= a_neg ? (~req_a + 1'b1) : req_a;
      dvs_reg  <= b_neg ? (~req_b + 1'b1) : req_b;
      q_sign   <= a_neg ^ b_neg;
      r_sign   <= a_neg;
      div_zero <= (req_b == '0);
    end else if (state == imuldiv_pkg::st_calc) begin
      // restore on borrow, keep the difference otherwise
      rem_reg <= q_bit ? diff[`IMULDIV_XLEN-1:0] : shifted[`IMULDIV_XLEN-1:0];
      quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], q_bit};
    end
  end

  // --------------------
  // sign fixes
  // --------------------
  logic [`IMULDIV_XLEN-1:0] quo_out;
  logic [`IMULDIV_XLEN-1:0] rem_out;

  // the zero divisor overrides the quotient to all ones;
  // the remainder already holds the dividend magnitude, so r_sign restores it
  // most negative / -1 gives magnitude 2^31 with a positive sign
  assign quo_out = div_zero ? '1 : (q_sign ? (~quo_reg + 1'b1) : quo_reg);
  assign rem_out = r_sign ? (~rem_reg + 1'b1) : rem_reg;

  assign resp_result = {rem_out, quo_out};

endmodule

/* rtl/imuldiv_mul_ctrl.sv */
/*
 * multiplier control FSM: val/rdy handshake, iteration counter and
 * datapath enables
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic b_lsb,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en,
  output logic result_mux_sel
);

  localparam logic [`IMULDIV_CNT_W-1:0] last_cnt = `IMULDIV_CNT_W'(`IMULDIV_ITERS - 1);

  imuldiv_pkg::iter_state_e state;
  logic [`IMULDIV_CNT_W-1:0] cnt;
  logic                      req_go;
  logic                      resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------
  // state and counter
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= imuldiv_pkg::st_calc;
            cnt   <= '0;
          end
        end
        imuldiv_pkg::st_calc: begin
          // exactly IMULDIV_ITERS calc cycles
          if (cnt == last_cnt) begin
            state <= imuldiv_pkg::st_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        imuldiv_pkg::st_done: begin
          // held here by back-pressure
          if (resp_go) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign req_rdy  = (state == imuldiv_pkg::st_idle);
  assign resp_val = (state == imuldiv_pkg::st_done);

  // load on accept (sel 0), shift every calc cycle (sel 1)
  assign a_en      = req_go || (state == imuldiv_pkg::st_calc);
  assign a_mux_sel = (state == imuldiv_pkg::st_calc);
  assign b_en      = a_en;
  assign b_mux_sel = a_mux_sel;

  // clear on accept, accumulate only when the current b bit is set
  assign result_en      = req_go || ((state == imuldiv_pkg::st_calc) && b_lsb);
  assign result_mux_sel = (state == imuldiv_pkg::st_calc);

endmodule

/* rtl/imuldiv_mul_dpath.sv */
/*
 * shift-and-add multiplier datapath working on operand magnitudes,
 * with the product sign applied at the output
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_mul_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     req_a,
  input  logic [`IMULDIV_XLEN-1:0]     req_b,
  input  logic                         a_en,
  input  logic                         a_mux_sel,
  input  logic                         b_en,
  input  logic                         b_mux_sel,
  input  logic                         result_en,
  input  logic                         result_mux_sel,
  output logic                         b_lsb,
  output logic [2*`IMULDIV_XLEN-1:0]   result
);

  logic [2*`IMULDIV_XLEN-1:0] a_reg;
  logic [`IMULDIV_XLEN-1:0]   b_reg;
  logic [2*`IMULDIV_XLEN-1:0] result_reg;
  logic                       sign_reg;

  // --------------------
  // operand magnitudes
  // --------------------
  logic sign_a;
  logic sign_b;
  logic [`IMULDIV_XLEN-1:0] mag_a;
  logic [`IMULDIV_XLEN-1:0] mag_b;

  assign sign_a = req_a[`IMULDIV_XLEN-1];
  assign sign_b = req_b[`IMULDIV_XLEN-1];
  // two's complement negate, most negative value maps to 2^31 unsigned
  assign mag_a  = sign_a ? (~req_a + 1'b1) : req_a;
  assign mag_b  = sign_b ? (~req_b + 1'b1) : req_b;

  // --------------------
  // registers
  // --------------------
  // a: zero-extended magnitude on load, shifted left each calc cycle
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? (a_reg << 1) : {{`IMULDIV_XLEN{1'b0}}, mag_a};
    end
  end

  // b: magnitude on load, shifted right so bit 0 picks the next add
  always_ff @(posedge clk) begin
    if (b_en) begin
      b_reg <= b_mux_sel ? (b_reg >> 1) : mag_b;
    end
  end

  // product sign is captured with the operand load
  always_ff @(posedge clk) begin
    if (a_en && !a_mux_sel) begin
      sign_reg <= sign_a ^ sign_b;
    end
  end

  // product accumulator, cleared on load
  always_ff @(posedge clk) begin
    if (reset) begin
      result_reg <= '0;
    end else if (result_en) begin
      result_reg <= result_mux_sel ? (result_reg + a_reg) : '0;
    end
  end

  assign b_lsb  = b_reg[0];
  // fix the sign at the end, -0 stays 0
  assign result = sign_reg ? (~result_reg + 1'b1) : result_reg;

endmodule

/* rtl/imuldiv_pkg.sv */
/*
 * shared types of the multiply/divide unit
 */

package imuldiv_pkg;

  // --------------------
  // request function code
  // --------------------
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,  // signed 32x32 multiply, full 64-bit product
    fn_div  = 2'd1,  // signed divide, remainder in upper half
    fn_divu = 2'd2   // unsigned divide, remainder in upper half
  } muldiv_fn_e;

  // --------------------
  // iterative unit state
  // --------------------
  typedef enum logic [1:0] {
    st_idle = 2'd0,  // waiting for a request
    st_calc = 2'd1,  // one bit per cycle
    st_done = 2'd2   // holding the response
  } iter_state_e;

endpackage

/* rtl/imuldiv_unit.sv */
/*
 * multiply/divide unit top: dispatches one request at a time by
 * function code and merges the two response streams
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::muldiv_fn_e      req_fn,
  input  logic [`IMULDIV_XLEN-1:0]     req_a,
  input  logic [`IMULDIV_XLEN-1:0]     req_b,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  // --------------------
  // request dispatch
  // --------------------
  logic is_mul;
  logic div_signed;
  logic mul_req_val;
  logic mul_req_rdy;
  logic div_req_val;
  logic div_req_rdy;

  assign is_mul     = (req_fn == imuldiv_pkg::fn_mul);
  assign div_signed = (req_fn == imuldiv_pkg::fn_div);

  // accept only when both units are idle
  assign req_rdy = mul_req_rdy && div_req_rdy;
  // gated with req_rdy so an idle unit never starts while the other is busy
  assign mul_req_val = req_val && req_rdy && is_mul;
  assign div_req_val = req_val && req_rdy && !is_mul;

  // --------------------
  // multiplier
  // --------------------
  logic mul_a_en;
  logic mul_a_mux_sel;
  logic mul_b_en;
  logic mul_b_mux_sel;
  logic mul_result_en;
  logic mul_result_mux_sel;
  logic mul_b_lsb;
  logic mul_resp_val;
  logic [2*`IMULDIV_XLEN-1:0] mul_result;

  imuldiv_mul_ctrl i_mul_ctrl (
    .clk            (clk),
    .reset          (reset),
    .req_val        (mul_req_val),
    .resp_rdy       (resp_rdy),
    .b_lsb          (mul_b_lsb),
    .req_rdy        (mul_req_rdy),
    .resp_val       (mul_resp_val),
    .a_en           (mul_a_en),
    .a_mux_sel      (mul_a_mux_sel),
    .b_en           (mul_b_en),
    .b_mux_sel      (mul_b_mux_sel),
    .result_en      (mul_result_en),
    .result_mux_sel (mul_result_mux_sel)
  );

  imuldiv_mul_dpath i_mul_dpath (
    .clk            (clk),
    .reset          (reset),
    .req_a          (req_a),
    .req_b          (req_b),
    .a_en           (mul_a_en),
    .a_mux_sel      (mul_a_mux_sel),
    .b_en           (mul_b_en),
    .b_mux_sel      (mul_b_mux_sel),
    .result_en      (mul_result_en),
    .result_mux_sel (mul_result_mux_sel),
    .b_lsb          (mul_b_lsb),
    .result         (mul_result)
  );

  // --------------------
  // divider
  // --------------------
  logic div_resp_val;
  logic [2*`IMULDIV_XLEN-1:0] div_result;

  imuldiv_div_iterative i_div (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (div_signed),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy)
  );

  // only one unit can hold an operation, so a plain OR and mux suffice
  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = mul_resp_val ? mul_result : div_result;

endmodule

/* run.sh */
#!/bin/sh
# build and run the multiply/divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module imuldiv_tb -f project.f -o imuldiv_sim

out=$(./obj_dir/imuldiv_sim)
echo "$out"

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
else
  exit 1
fi

/* verif/imuldiv_assertions.sv */
/*
 * handshake properties of the multiply/divide unit, bound to the top
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_assertions (
  input logic                         clk,
  input logic                         reset,
  input logic                         req_rdy,
  input logic                         resp_val,
  input logic                         resp_rdy,
  input logic [2*`IMULDIV_XLEN-1:0]   resp_result
);

  // a pending response blocks new requests
  assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
    else $error("req_rdy high while a response is pending");

  // stalled response keeps its value
  assert property (@(posedge clk) disable iff (reset)
                   (resp_val && !resp_rdy) |=> $stable(resp_result))
    else $error("resp_result changed while stalled by resp_rdy");

  // nothing comes out of reset
  assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

  // one operation in flight at most
  assert property (@(posedge clk) !(req_rdy && resp_val))
    else $error("req_rdy and resp_val both high");

endmodule

bind imuldiv_unit imuldiv_assertions i_assertions (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

/* verif/imuldiv_tb.sv */
/*
 * multiply/divide unit testbench: random requests with back-pressure,
 * checked against a 64-bit reference model
 */

`timescale 1ns/1ps
`include "imuldiv_config.svh"

module imuldiv_tb;

  // watchdog limit of 300 operations at 60 cycles each
  localparam int max_cycles = 300 * 60;
  // cycles from the accept cycle to the first cycle with resp_val
  localparam int exp_latency = `IMULDIV_ITERS + 1;

  logic                        clk;
  logic                        reset;
  imuldiv_pkg::muldiv_fn_e     req_fn;
  logic [`IMULDIV_XLEN-1:0]    req_a;
  logic [`IMULDIV_XLEN-1:0]    req_b;
  logic                        req_val;
  logic                        req_rdy;
  logic [2*`IMULDIV_XLEN-1:0]  resp_result;
  logic                        resp_val;
  logic                        resp_rdy;

  int          n_checks = 0;
  int          n_mismatch = 0;
  int          n_other = 0;
  int          cycle_cnt = 0;

  tb_clock i_clock (.clk(clk));

  imuldiv_unit i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // --------------------
  // reference model
  // --------------------
  function automatic logic [63:0] model_result(input imuldiv_pkg::muldiv_fn_e fn,
                                               input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      prod;
    logic [31:0] q;
    logic [31:0] r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    q = '0;
    r = '0;
    case (fn)
      imuldiv_pkg::fn_mul: begin
        prod = sa * sb;
        return prod;
      end
      imuldiv_pkg::fn_div: begin
        // zero divisor and overflow first and then truncation toward zero
        if (b == 32'h0) begin
          q = '1;
          r = a;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = a;
          r = '0;
        end else begin
          q = 32'(sa / sb);
          r = 32'(sa % sb);
        end
      end
      default: begin
        if (b == 32'h0) begin
          q = '1;
          r = a;
        end else begin
          q = a / b;
          r = a % b;
        end
      end
    endcase
    return {r, q};
  endfunction

  // operand mix leaning on the edges of the signed range
  function automatic logic [31:0] pick_operand();
    int kind;
    kind = $urandom_range(0, 9);
    case (kind)
      0: return 32'h0;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      3: return 32'h7fff_ffff;
      4: return 32'($urandom_range(1, 100));
      5: return 32'h0 - 32'($urandom_range(1, 100));
      default: return $urandom();
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    n_checks++;
    assert (got === exp) else begin
      n_mismatch++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  task automatic check_condition(input logic cond, input string what);
    n_checks++;
    assert (cond) else begin
      n_other++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  // --------------------
  // one request through to its response
  // --------------------
  task automatic run_op(input imuldiv_pkg::muldiv_fn_e fn,
                        input logic [31:0] a, input logic [31:0] b);
    logic [63:0] exp_res;
    int          lat;
    int          hold;
    exp_res = model_result(fn, a, b);
    hold = $urandom_range(0, 10);
    while (!req_rdy) @(negedge clk);
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (hold == 0);
    @(negedge clk);
    // accepted on the edge just passed so the operands are already registered
    req_val = 1'b0;
    req_a   = $urandom();
    req_b   = $urandom();
    lat = 1;
    while (!resp_val) begin
      @(negedge clk);
      lat++;
    end
    n_checks++;
    assert (lat == exp_latency) else begin
      n_mismatch++;
      $display("mismatch at %0t ns: resp_val latency expected %0d actual %0d",
               $time, exp_latency, lat);
    end
    // back-pressure
    repeat (hold) @(negedge clk);
    resp_rdy = 1'b1;
    check_condition(resp_val, "response dropped while resp_rdy was low");
    check_value("resp_result", exp_res, resp_result);
    @(negedge clk);
    resp_rdy = 1'b0;
    check_condition(!resp_val, "response still valid after it transferred");
    check_condition(req_rdy, "req_rdy low on the cycle after a response transfer");
  endtask

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: responses stopped arriving after %0d cycles", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hb85f_c7f5));
    reset    = 1'b1;
    req_fn   = imuldiv_pkg::fn_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_condition(req_rdy && !resp_val, "unit not idle after reset");

    repeat (100) run_op(imuldiv_pkg::fn_mul, pick_operand(), pick_operand());
    repeat (100) run_op(imuldiv_pkg::fn_div, pick_operand(), pick_operand());
    repeat (60) run_op(imuldiv_pkg::fn_divu, pick_operand(), pick_operand());

    // zero divisors and the signed overflow
    run_op(imuldiv_pkg::fn_div, 32'h1234_5678, 32'h0);
    run_op(imuldiv_pkg::fn_div, 32'h8000_0000, 32'h0);
    run_op(imuldiv_pkg::fn_divu, 32'hdead_beef, 32'h0);
    run_op(imuldiv_pkg::fn_divu, 32'h0, 32'h0);
    run_op(imuldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    run_op(imuldiv_pkg::fn_divu, 32'h8000_0000, 32'hffff_ffff);

    @(negedge clk);
    $display("checks: %0d, mismatches: %0d, other errors: %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* verif/tb_clock.sv */
/*
 * testbench clock source, 8 ns period
 */

`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // half period in ns
  localparam int half_period = 4;

  initial clk = 1'b0;

  always #half_period clk = ~clk;

endmodule
